// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = top_vga_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS      = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/top_vga_tb.sv
`timescale 1ns/10ps

module top_vga_tb;

    import vga_pkg::*;
    import mouse_pkg::*;

    // reduced timing so a frame is about twelve hundred cycles
    localparam int H_ACT    = 32;
    localparam int H_FP     = 2;
    localparam int H_SW     = 4;
    localparam int H_BP     = 3;
    localparam int V_ACT    = 24;
    localparam int V_FP     = 1;
    localparam int V_SW     = 2;
    localparam int V_BP     = 2;
    localparam int CSIZE    = 4;
    localparam int H_TOT    = H_ACT + H_FP + H_SW + H_BP;
    localparam int V_TOT    = V_ACT + V_FP + V_SW + V_BP;
    localparam int FRAME    = H_TOT * V_TOT;
    // bound for any single wait on the video outputs
    localparam int WAIT_MAX = 2 * FRAME + 100;
    // ps2 clock half period in clk cycles
    localparam int PS2_HALF = 8;

    logic        clk;
    logic        rst;
    logic        ps2_clk;
    logic        ps2_data;
    logic        vs;
    logic        hs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;
    // one captured frame indexed by row and column
    logic [11:0] pixels [V_ACT][H_ACT];
    // expected pointer
    int          exp_x;
    int          exp_y;
    logic        exp_left;

    top_vga #(
        .H_ACTIVE(H_ACT), .H_FRONT(H_FP), .H_SYNC(H_SW), .H_BACK(H_BP),
        .V_ACTIVE(V_ACT), .V_FRONT(V_FP), .V_SYNC(V_SW), .V_BACK(V_BP),
        .CURSOR_SIZE(CSIZE)
    ) u_dut (
        .clk,
        .rst,
        .ps2_clk,
        .ps2_data,
        .vs,
        .hs,
        .r,
        .g,
        .b
    );

    always #2 clk = ~clk;

    task automatic stop_run();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s to change", what);
        stop_run();
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    // sel 0 picks hs and sel 1 picks vs
    function automatic logic line_level(input bit sel);
        return sel ? vs : hs;
    endfunction

    task automatic wait_level(input bit sel, input logic level);
        int n;
        n = 0;
        while (line_level(sel) !== level) begin
            @(negedge clk);
            n++;
            if (n > WAIT_MAX) timed_out(sel ? "vs" : "hs");
        end
    endtask

    // returns on the first low sample after hs was high
    task automatic hs_fall();
        wait_level(1'b0, 1'b1);
        wait_level(1'b0, 1'b0);
    endtask

    task automatic sync_black();
        assert (!(hs || vs) || {r, g, b} == 12'h000) else begin
            $display("error %0t ns: rgb %h while in sync", $time, {r, g, b});
            stop_run();
        end
    endtask

    // high time and full period of one sync pulse in clk cycles
    task automatic measure_pulse(input bit sel, output int high_len, output int period);
        int low_len;
        wait_level(sel, 1'b0);
        wait_level(sel, 1'b1);
        high_len = 0;
        low_len = 0;
        while (line_level(sel)) begin
            sync_black();
            high_len++;
            @(negedge clk);
            if (high_len > WAIT_MAX) timed_out(sel ? "vs" : "hs");
        end
        while (!line_level(sel)) begin
            sync_black();
            low_len++;
            @(negedge clk);
            if (low_len > WAIT_MAX) timed_out(sel ? "vs" : "hs");
        end
        period = high_len + low_len;
    endtask

    // start low, data lsb first, odd parity, stop high
    task automatic send_byte(input logic [7:0] data, input bit bad_parity);
        logic [10:0] frame;
        int i;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (i = 0; i < 11; i++) begin
            ps2_data = frame[i];
            idle(PS2_HALF);
            ps2_clk = 1'b0;
            idle(PS2_HALF);
            ps2_clk = 1'b1;
        end
        idle(4 * PS2_HALF);
    endtask

    // status, dx, dy with 9-bit deltas
    task automatic send_packet(input int dx, input int dy, input bit left, input bit bad_dx);
        logic [8:0] dx9;
        logic [8:0] dy9;
        logic [7:0] status;
        dx9 = 9'(dx);
        dy9 = 9'(dy);
        status = 8'h00;
        status[STAT_LEFT] = left;
        status[STAT_ALWAYS1] = 1'b1;
        status[STAT_XSIGN] = dx9[8];
        status[STAT_YSIGN] = dy9[8];
        send_byte(status, 1'b0);
        send_byte(dx9[7:0], bad_dx);
        send_byte(dy9[7:0], 1'b0);
    endtask

    // screen y grows down while ps2 y grows up
    task automatic apply_move(input int dx, input int dy, input bit left);
        exp_x = exp_x + dx;
        exp_y = exp_y - dy;
        if (exp_x < 0) exp_x = 0;
        if (exp_x > H_ACT - 1) exp_x = H_ACT - 1;
        if (exp_y < 0) exp_y = 0;
        if (exp_y > V_ACT - 1) exp_y = V_ACT - 1;
        exp_left = left;
    endtask

    // active pixels of the next frame
    task automatic capture_frame();
        int row;
        int col;
        wait_level(1'b1, 1'b0);
        wait_level(1'b1, 1'b1);
        wait_level(1'b1, 1'b0);
        // the fall in the last back porch line leads into row 0
        repeat (V_BP - 1) hs_fall();
        for (row = 0; row < V_ACT; row++) begin
            hs_fall();
            idle(H_BP);
            for (col = 0; col < H_ACT; col++) begin
                pixels[row][col] = {r, g, b};
                @(negedge clk);
            end
        end
    endtask

    function automatic logic [11:0] expected_pixel(input int col, input int row);
        if (col >= exp_x && col < exp_x + CSIZE && row >= exp_y && row < exp_y + CSIZE)
            return exp_left ? COLOR_CURSOR_PRESSED : COLOR_CURSOR;
        if (col == 0 || col == H_ACT - 1 || row == 0 || row == V_ACT - 1)
            return COLOR_BORDER;
        if (col < H_ACT / 2)
            return COLOR_LEFT;
        return COLOR_RIGHT;
    endfunction

    task automatic compare_frame();
        int row;
        int col;
        for (row = 0; row < V_ACT; row++) begin
            for (col = 0; col < H_ACT; col++) begin
                assert (pixels[row][col] == expected_pixel(col, row)) else begin
                    $display("error %0t ns: pixel (%0d, %0d) is %h, expected %h", $time,
                             col, row, pixels[row][col], expected_pixel(col, row));
                    stop_run();
                end
            end
        end
    endtask

    // the second frame is sure to hold the new pointer
    task automatic frame_after_packet();
        capture_frame();
        capture_frame();
        compare_frame();
    endtask

    task automatic sync_timing();
        int hi;
        int per;
        measure_pulse(1'b0, hi, per);
        assert (hi == H_SW && per == H_TOT) else begin
            $display("error %0t ns: hs high %0d of %0d cycles", $time, hi, per);
            stop_run();
        end
        measure_pulse(1'b1, hi, per);
        assert (hi == V_SW * H_TOT && per == FRAME) else begin
            $display("error %0t ns: vs high %0d of %0d cycles", $time, hi, per);
            stop_run();
        end
    endtask

    task automatic reset_cursor();
        capture_frame();
        compare_frame();
    endtask

    task automatic random_moves();
        int k;
        int dx;
        int dy;
        for (k = 0; k < 8; k++) begin
            dx = int'($urandom % 11) - 5;
            dy = int'($urandom % 11) - 5;
            send_packet(dx, dy, 1'b0, 1'b0);
            apply_move(dx, dy, 1'b0);
            frame_after_packet();
        end
    endtask

    // far left move pins the cursor to column 0
    task automatic button_clamp();
        send_packet(-100, 0, 1'b1, 1'b0);
        apply_move(-100, 0, 1'b1);
        frame_after_packet();
    endtask

    task automatic error_reject();
        // dy byte 0 has bit 3 clear and cannot pass as a status byte
        send_packet(5, 0, 1'b0, 1'b1);
        frame_after_packet();
        send_packet(3, -2, 1'b0, 1'b0);
        apply_move(3, -2, 1'b0);
        frame_after_packet();
    endtask

    initial begin
        void'($urandom(32'h66ac));
        clk = 1'b0;
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        exp_x = H_ACT / 2;
        exp_y = V_ACT / 2;
        exp_left = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        sync_timing();
        reset_cursor();
        random_moves();
        button_clamp();
        error_reject();
        $display("No errors");
        $finish;
    end

endmodule

// File: build.f
source/vga_pkg.sv
source/mouse_pkg.sv
source/vga_timing.sv
source/draw_background.sv
source/ps2_mouse_rx.sv
source/draw_mouse.sv
source/top_vga.sv
bench/top_vga_tb.sv

// File: source/draw_background.sv
`timescale 1ns/10ps

module draw_background #(
    parameter int H_ACTIVE,
    parameter int V_ACTIVE
) (
    input  logic              clk,
    input  logic              rst,
    input  vga_pkg::vga_sig_t vga_in,
    output vga_pkg::vga_sig_t vga_out
);

    import vga_pkg::*;

    // last visible column and row, and the split between regions
    localparam logic [10:0] H_LAST = 11'(H_ACTIVE - 1);
    localparam logic [10:0] V_LAST = 11'(V_ACTIVE - 1);
    localparam logic [10:0] H_HALF = 11'(H_ACTIVE / 2);

    logic [11:0] rgb_nxt;

    // background colour for the incoming pixel
    always_comb begin
        if (vga_in.hblnk || vga_in.vblnk) begin
            // black during blanking
            rgb_nxt = '0;
        end else if (vga_in.hcount == '0 || vga_in.hcount == H_LAST ||
                     vga_in.vcount == '0 || vga_in.vcount == V_LAST) begin
            rgb_nxt = COLOR_BORDER;
        end else if (vga_in.hcount < H_HALF) begin
            rgb_nxt = COLOR_LEFT;
        end else begin
            rgb_nxt = COLOR_RIGHT;
        end
    end

    // one stage, timing fields delayed with the colour
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out     <= vga_in;
            vga_out.rgb <= rgb_nxt;
        end
    end

endmodule

// File: source/draw_mouse.sv
`timescale 1ns/10ps

module draw_mouse #(
    parameter int H_ACTIVE,
    parameter int V_ACTIVE,
    parameter int CURSOR_SIZE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  mouse_pkg::mouse_state_t mouse,
    input  vga_pkg::vga_sig_t       vga_in,
    output vga_pkg::vga_sig_t       vga_out
);

    import vga_pkg::*;
    import mouse_pkg::*;

    localparam logic [11:0] SIZE = 12'(CURSOR_SIZE);

    logic         vsync_last;
    // pointer held steady for the whole frame
    mouse_state_t frame_pos;
    logic [11:0]  dx;
    logic [11:0]  dy;
    logic         hit;

    // offsets from the cursor corner
    // negative offsets wrap high and fail the size test
    assign dx  = 12'(vga_in.hcount) - frame_pos.xpos;
    assign dy  = 12'(vga_in.vcount) - frame_pos.ypos;
    assign hit = !vga_in.hblnk && !vga_in.vblnk && (dx < SIZE) && (dy < SIZE);

    // latch pointer at vsync start
    always_ff @(posedge clk) begin
        if (rst) begin
            vsync_last     <= 1'b0;
            frame_pos.xpos <= 12'(H_ACTIVE / 2);
            frame_pos.ypos <= 12'(V_ACTIVE / 2);
            frame_pos.left <= 1'b0;
        end else begin
            vsync_last <= vga_in.vsync;
            if (vga_in.vsync && !vsync_last) begin
                frame_pos <= mouse;
            end
        end
    end

    // one stage, cursor painted over background
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out <= vga_in;
            if (hit) begin
                vga_out.rgb <= frame_pos.left ? COLOR_CURSOR_PRESSED : COLOR_CURSOR;
            end
        end
    end

endmodule

// File: source/mouse_pkg.sv
package mouse_pkg;

    // pointer state seen by the video side
    // position in pixels, origin top left
    typedef struct packed {
        logic [11:0] xpos;
        logic [11:0] ypos;
        logic        left;
    } mouse_state_t;

    // bit positions in the packet status byte
    // left button
    localparam int STAT_LEFT    = 0;
    // always set in a status byte, used to find packet start
    localparam int STAT_ALWAYS1 = 3;
    // ninth bit of dx
    localparam int STAT_XSIGN   = 4;
    // ninth bit of dy
    localparam int STAT_YSIGN   = 5;

    // packet is status, dx, dy
    // dx and dy are 9-bit two's complement with sign in status
    // positive dy means the mouse moved away from the user

endpackage

// File: source/ps2_mouse_rx.sv
`timescale 1ns/10ps

module ps2_mouse_rx #(
    parameter int H_ACTIVE,
    parameter int V_ACTIVE
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    ps2_clk,
    input  logic                    ps2_data,
    output mouse_pkg::mouse_state_t mouse
);

    import mouse_pkg::*;

    // clamp limits, signed to catch moves past zero
    localparam logic signed [13:0] X_MAX = 14'(H_ACTIVE - 1);
    localparam logic signed [13:0] Y_MAX = 14'(V_ACTIVE - 1);

    logic               clk_meta;
    logic               clk_sync;
    logic               clk_last;
    logic               data_meta;
    logic               data_sync;
    logic               clk_fall;
    // start, data, parity as they arrive, lsb first
    logic [9:0]         shift;
    logic [3:0]         bit_cnt;
    logic [15:0]        idle_cnt;
    logic [10:0]        frame;
    logic [7:0]         rx_byte;
    logic               frame_ok;
    logic [1:0]         byte_idx;
    logic [7:0]         status;
    logic [7:0]         dx_byte;
    logic [7:0]         dy_byte;
    logic               pkt_done;
    logic signed [13:0] x_sum;
    logic signed [13:0] y_sum;

    // two-flop synchronisers, ps2 clock idles high
    always_ff @(posedge clk) begin
        if (rst) begin
            clk_meta <= 1'b1;
            clk_sync <= 1'b1;
            clk_last <= 1'b1;
        end else begin
            clk_meta <= ps2_clk;
            clk_sync <= clk_meta;
            clk_last <= clk_sync;
        end
    end

    always_ff @(posedge clk) begin
        data_meta <= ps2_data;
        data_sync <= data_meta;
    end

    assign clk_fall = clk_last && !clk_sync;

    // full frame once the stop bit is on the line
    assign frame    = {data_sync, shift};
    assign rx_byte  = frame[8:1];
    // start low, stop high, odd parity over data and parity bit
    assign frame_ok = !frame[0] && frame[10] && (^frame[9:1]);

    // bit and byte counting, idle timeout
    always_ff @(posedge clk) begin
        if (rst) begin
            bit_cnt  <= '0;
            idle_cnt <= '0;
            byte_idx <= '0;
            pkt_done <= 1'b0;
        end else begin
            pkt_done <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    bit_cnt <= '0;
                    if (!frame_ok) begin
                        // drop the partial packet
                        byte_idx <= '0;
                    end else begin
                        case (byte_idx)
                            // wait for a byte that can be a status byte
                            2'd0:    byte_idx <= rx_byte[STAT_ALWAYS1] ? 2'd1 : 2'd0;
                            2'd1:    byte_idx <= 2'd2;
                            default: begin
                                byte_idx <= '0;
                                pkt_done <= 1'b1;
                            end
                        endcase
                    end
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else if (&idle_cnt) begin
                // line went quiet mid frame or packet
                idle_cnt <= '0;
                bit_cnt  <= '0;
                byte_idx <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    // shift register and packet bytes
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift <= {data_sync, shift[9:1]};
        end
        if (clk_fall && bit_cnt == 4'd10 && frame_ok) begin
            case (byte_idx)
                2'd0:    status  <= rx_byte;
                2'd1:    dx_byte <= rx_byte;
                default: dy_byte <= rx_byte;
            endcase
        end
    end

    // 9-bit deltas sign extended
    // screen y grows downward, so dy is subtracted
    always_comb begin
        x_sum = $signed({2'b00, mouse.xpos}) + 14'($signed({status[STAT_XSIGN], dx_byte}));
        y_sum = $signed({2'b00, mouse.ypos}) - 14'($signed({status[STAT_YSIGN], dy_byte}));
    end

    // pointer update on each packet, clamped to the screen
    always_ff @(posedge clk) begin
        if (rst) begin
            mouse.xpos <= 12'(H_ACTIVE / 2);
            mouse.ypos <= 12'(V_ACTIVE / 2);
            mouse.left <= 1'b0;
        end else if (pkt_done) begin
            if (x_sum < 0) begin
                mouse.xpos <= '0;
            end else if (x_sum > X_MAX) begin
                mouse.xpos <= 12'(X_MAX);
            end else begin
                mouse.xpos <= x_sum[11:0];
            end
            if (y_sum < 0) begin
                mouse.ypos <= '0;
            end else if (y_sum > Y_MAX) begin
                mouse.ypos <= 12'(Y_MAX);
            end else begin
                mouse.ypos <= y_sum[11:0];
            end
            mouse.left <= status[STAT_LEFT];
        end
    end

endmodule

// File: source/top_vga.sv
`timescale 1ns/10ps

module top_vga #(
    parameter int H_ACTIVE    = vga_pkg::H_ACTIVE,
    parameter int H_FRONT     = vga_pkg::H_FRONT,
    parameter int H_SYNC      = vga_pkg::H_SYNC,
    parameter int H_BACK      = vga_pkg::H_BACK,
    parameter int V_ACTIVE    = vga_pkg::V_ACTIVE,
    parameter int V_FRONT     = vga_pkg::V_FRONT,
    parameter int V_SYNC      = vga_pkg::V_SYNC,
    parameter int V_BACK      = vga_pkg::V_BACK,
    parameter int CURSOR_SIZE = 8
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    output logic       vs,
    output logic       hs,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    import vga_pkg::*;
    import mouse_pkg::*;

    // video path, one struct per stage
    vga_sig_t     tim_sig;
    vga_sig_t     bg_sig;
    vga_sig_t     out_sig;
    mouse_state_t mouse_st;

    assign vs        = out_sig.vsync;
    assign hs        = out_sig.hsync;
    assign {r, g, b} = out_sig.rgb;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_vga_timing (
        .clk,
        .rst,
        .vga_out(tim_sig)
    );

    draw_background #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_draw_background (
        .clk,
        .rst,
        .vga_in(tim_sig),
        .vga_out(bg_sig)
    );

    ps2_mouse_rx #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_ps2_mouse_rx (
        .clk,
        .rst,
        .ps2_clk,
        .ps2_data,
        .mouse(mouse_st)
    );

    draw_mouse #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .CURSOR_SIZE(CURSOR_SIZE)
    ) u_draw_mouse (
        .clk,
        .rst,
        .mouse(mouse_st),
        .vga_in(bg_sig),
        .vga_out(out_sig)
    );

endmodule

// File: source/vga_pkg.sv
package vga_pkg;

    // default 640x480 timing, horizontal in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // vertical in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

    // 12-bit colours, 4 bits each of r g b
    localparam logic [11:0] COLOR_BORDER         = 12'hfff;
    localparam logic [11:0] COLOR_LEFT           = 12'h248;
    localparam logic [11:0] COLOR_RIGHT          = 12'h842;
    localparam logic [11:0] COLOR_CURSOR         = 12'hff0;
    localparam logic [11:0] COLOR_CURSOR_PRESSED = 12'hf00;

    // one pixel of video, passed stage to stage
    // 38 bits total
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        hblnk;
        logic        vsync;
        logic        vblnk;
        logic [11:0] rgb;
    } vga_sig_t;

endpackage

// File: source/vga_timing.sv
`timescale 1ns/10ps

module vga_timing #(
    parameter int H_ACTIVE,
    parameter int H_FRONT,
    parameter int H_SYNC,
    parameter int H_BACK,
    parameter int V_ACTIVE,
    parameter int V_FRONT,
    parameter int V_SYNC,
    parameter int V_BACK
) (
    input  logic              clk,
    input  logic              rst,
    output vga_pkg::vga_sig_t vga_out
);

    // interval boundaries as counter values
    localparam logic [10:0] H_LAST       = 11'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam logic [10:0] H_BLNK_START = 11'(H_ACTIVE);
    localparam logic [10:0] H_SYNC_START = 11'(H_ACTIVE + H_FRONT);
    localparam logic [10:0] H_SYNC_END   = 11'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam logic [10:0] V_LAST       = 11'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam logic [10:0] V_BLNK_START = 11'(V_ACTIVE);
    localparam logic [10:0] V_SYNC_START = 11'(V_ACTIVE + V_FRONT);
    localparam logic [10:0] V_SYNC_END   = 11'(V_ACTIVE + V_FRONT + V_SYNC);

    logic [10:0] hcnt;
    logic [10:0] vcnt;

    // free-running counters
    // vertical steps once per horizontal wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (hcnt == H_LAST) begin
            hcnt <= '0;
            if (vcnt == V_LAST) begin
                vcnt <= '0;
            end else begin
                vcnt <= vcnt + 1'b1;
            end
        end else begin
            hcnt <= hcnt + 1'b1;
        end
    end

    // decode intervals, one cycle behind the counters
    // sync high between front and back porch
    always_ff @(posedge clk) begin
        if (rst) begin
            vga_out <= '0;
        end else begin
            vga_out.hcount <= hcnt;
            vga_out.vcount <= vcnt;
            vga_out.hblnk  <= (hcnt >= H_BLNK_START);
            vga_out.hsync  <= (hcnt >= H_SYNC_START) && (hcnt < H_SYNC_END);
            vga_out.vblnk  <= (vcnt >= V_BLNK_START);
            vga_out.vsync  <= (vcnt >= V_SYNC_START) && (vcnt < V_SYNC_END);
            // colour added downstream
            vga_out.rgb    <= '0;
        end
    end

endmodule
